/* hdl/credit_link_consts.svh */
// Shared sizes for the credit link
// CL_CNT_W must hold 0 to CL_BUF_DEPTH and CL_CHG_W must hold 0 to CL_MAX_RETURN
// CL_BUF_DEPTH is also the total number of credits in circulation
`ifndef CREDIT_LINK_CONSTS_SVH
`define CREDIT_LINK_CONSTS_SVH

// Flit and buffer sizing
`define CL_DATA_W 32
`define CL_BUF_DEPTH 8

// Credit return and link length
`define CL_MAX_RETURN 2
`define CL_LINK_STAGES 3

// Counter and change widths
`define CL_CNT_W 4
`define CL_CHG_W 2

`endif

/* hdl/credit_link_pkg.sv */
// Types shared by the credit link blocks
// Widths come from the constants header
`include "credit_link_consts.svh"

package credit_link_pkg;

  // One data flit on the forward link
  typedef logic [`CL_DATA_W-1:0] flit_t;

  // Credit pool value, 0 up to the buffer depth
  typedef logic [`CL_CNT_W-1:0] credit_cnt_t;

  // Increment or decrement amount, 0 up to the max return
  typedef logic [`CL_CHG_W-1:0] credit_chg_t;

endpackage

/* hdl/credit_counter.sv */
// Credit pool usable at either end of a credit link
// The user must keep the pool from overflowing the credit_cnt_t range
// Decrements that do not fit in available are held off, never partially taken
`timescale 1ns/100ps

module credit_counter (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         incr_valid,
  input  credit_link_pkg::credit_chg_t incr,
  input  logic                         decr_valid,
  input  credit_link_pkg::credit_chg_t decr,
  output logic                         decr_ready,
  input  credit_link_pkg::credit_cnt_t initial_value,
  input  credit_link_pkg::credit_cnt_t withhold,
  output credit_link_pkg::credit_cnt_t value,
  output credit_link_pkg::credit_cnt_t available
);
  import credit_link_pkg::*;

  credit_cnt_t incr_amt;
  credit_cnt_t decr_amt;
  credit_cnt_t value_plus_incr;
  credit_cnt_t value_next;
  logic        decr_take;
  logic        value_load;

  // ----------------------------------------------------------------------
  // Next value
  // ----------------------------------------------------------------------

  // Zero-extend the change amounts to the pool width
  assign incr_amt = incr_valid ? credit_cnt_t'(incr) : '0;

  // A decrement only counts once it has been accepted
  assign decr_take = decr_valid && decr_ready;
  assign decr_amt  = decr_take ? credit_cnt_t'(decr) : '0;

  assign value_plus_incr = value + incr_amt;
  assign value_next      = value_plus_incr - decr_amt;

  // Pool only moves on an increment or an accepted decrement
  assign value_load = incr_valid || decr_take;

  // ----------------------------------------------------------------------
  // Available credit
  // ----------------------------------------------------------------------

  // Same-cycle increment counts, withheld credits do not
  // Decrement stays out of this sum, else decr_ready would loop back on itself
  assign available = (value_plus_incr > withhold) ? value_plus_incr - withhold : '0;

  // Request fits when its full amount is covered
  // Independent of decr_valid so a ready can be shown ahead of a request
  assign decr_ready = credit_cnt_t'(decr) <= available;

  // ----------------------------------------------------------------------
  // Pool register
  // ----------------------------------------------------------------------

  // Reset value comes from a port so each end can start differently
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= initial_value;
    end else if (value_load) begin
      value <= value_next;
    end
  end

endmodule

/* hdl/link_retimer.sv */
// Pipeline of valid-qualified registers standing in for wire distance
// Stages must be at least 1; latency is exactly Stages cycles
// Payload bits hold stale data whenever their valid bit is low
`timescale 1ns/100ps

module link_retimer #(
  parameter int Stages = 1,
  parameter int Width  = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic [Width-1:0] in_payload,
  output logic             out_valid,
  output logic [Width-1:0] out_payload
);

  logic [Stages-1:0] valid_q;
  logic [Width-1:0]  payload_q [Stages];

  // Valid chain, the only state cleared in reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < Stages; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Payload chain; each stage loads only behind a valid bit
  always_ff @(posedge clk) begin
    if (in_valid) begin
      payload_q[0] <= in_payload;
    end
    for (int i = 1; i < Stages; i++) begin
      if (valid_q[i-1]) begin
        payload_q[i] <= payload_q[i-1];
      end
    end
  end

  // Far end of the link
  assign out_valid   = valid_q[Stages-1];
  assign out_payload = payload_q[Stages-1];

endmodule

/* hdl/credit_sender.sv */
// Sending end of the credit link
// Starts with no credits, so nothing is accepted until the receiver hands some out
// credit_hold above the pool simply shuts the producer off
`timescale 1ns/100ps

module credit_sender (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  credit_link_pkg::flit_t       in_data,
  output logic                         in_ready,
  input  credit_link_pkg::credit_cnt_t credit_hold,
  output credit_link_pkg::credit_cnt_t credit_available,
  input  logic                         ret_valid,
  input  credit_link_pkg::credit_chg_t ret_count,
  output logic                         fwd_valid,
  output credit_link_pkg::flit_t       fwd_data
);
  import credit_link_pkg::*;

  logic accept;

  // One credit per flit; returned credits feed straight in as the increment
  // so they can be spent in the cycle they land
  credit_counter u_credit_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .incr_valid    (ret_valid),
    .incr          (ret_count),
    .decr_valid    (in_valid),
    .decr          (credit_chg_t'(1)),
    .decr_ready    (in_ready),
    .initial_value (credit_cnt_t'(0)),
    .withhold      (credit_hold),
    .value         (),
    .available     (credit_available)
  );

  // Producer handshake
  assign accept = in_valid && in_ready;

  // ----------------------------------------------------------------------
  // Launch register onto the forward link
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fwd_valid <= 1'b0;
    end else begin
      fwd_valid <= accept;
    end
  end

  // Payload only loads on an accepted flit
  always_ff @(posedge clk) begin
    if (accept) begin
      fwd_data <= in_data;
    end
  end

endmodule

/* hdl/credit_receiver.sv */
// Receiving end of the credit link
// Relies on the sender never launching more flits than free slots
// Starts holding all CL_BUF_DEPTH credits and returns up to CL_MAX_RETURN per cycle
`timescale 1ns/100ps
`include "credit_link_consts.svh"

module credit_receiver (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         fwd_valid,
  input  credit_link_pkg::flit_t       fwd_data,
  output logic                         out_valid,
  output credit_link_pkg::flit_t       out_data,
  input  logic                         out_ready,
  output logic                         ret_valid,
  output credit_link_pkg::credit_chg_t ret_count
);
  import credit_link_pkg::*;

  localparam int PtrW = $clog2(`CL_BUF_DEPTH);

  flit_t       buf_mem [`CL_BUF_DEPTH];
  logic [PtrW-1:0] wr_ptr;
  logic [PtrW-1:0] rd_ptr;
  credit_cnt_t occupancy;
  logic        push;
  logic        pop;
  logic        pop_q;
  credit_cnt_t rx_available;
  credit_chg_t claim;
  logic        claim_valid;

  // ----------------------------------------------------------------------
  // Landing buffer
  // ----------------------------------------------------------------------

  // Every link flit lands; credits guarantee there is room
  assign push = fwd_valid;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      buf_mem[wr_ptr] <= fwd_data;
    end
  end

  // Pointers wrap at the buffer depth and occupancy tracks both sides
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PtrW'(`CL_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PtrW'(`CL_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // Consumer side reads the oldest slot
  assign out_valid = occupancy != '0;
  assign out_data  = buf_mem[rd_ptr];

  // ----------------------------------------------------------------------
  // Credit return
  // ----------------------------------------------------------------------

  // Freed slot is counted the cycle after its pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pop_q <= 1'b0;
    end else begin
      pop_q <= pop;
    end
  end

  // Claim never exceeds available so the counter always takes it
  credit_counter u_credit_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .incr_valid    (pop_q),
    .incr          (credit_chg_t'(1)),
    .decr_valid    (claim_valid),
    .decr          (claim),
    .decr_ready    (),
    .initial_value (credit_cnt_t'(`CL_BUF_DEPTH)),
    .withhold      (credit_cnt_t'(0)),
    .value         (),
    .available     (rx_available)
  );

  // Batch of min(available, CL_MAX_RETURN)
  assign claim = (rx_available > credit_cnt_t'(`CL_MAX_RETURN)) ?
                 credit_chg_t'(`CL_MAX_RETURN) : credit_chg_t'(rx_available);
  assign claim_valid = claim != '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ret_valid <= 1'b0;
    end else begin
      ret_valid <= claim_valid;
    end
  end

  // Count register loads only with a return
  always_ff @(posedge clk) begin
    if (claim_valid) begin
      ret_count <= claim;
    end
  end

endmodule

/* hdl/credit_link.sv */
// Top level of the credit-flow-controlled link
// Producer and consumer ends are valid/ready; the link itself has no back-pressure
// credit_hold shrinks the sender window while traffic runs
`timescale 1ns/100ps
`include "credit_link_consts.svh"

module credit_link (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  credit_link_pkg::flit_t       in_data,
  output logic                         in_ready,
  output logic                         out_valid,
  output credit_link_pkg::flit_t       out_data,
  input  logic                         out_ready,
  input  credit_link_pkg::credit_cnt_t credit_hold,
  output credit_link_pkg::credit_cnt_t credit_available
);
  import credit_link_pkg::*;

  // Forward path, sender side and receiver side of the retimer
  logic        snd_fwd_valid;
  flit_t       snd_fwd_data;
  logic        rcv_fwd_valid;
  flit_t       rcv_fwd_data;

  // Return path, receiver side and sender side of the retimer
  logic        rcv_ret_valid;
  credit_chg_t rcv_ret_count;
  logic        snd_ret_valid;
  credit_chg_t snd_ret_count;

  // ----------------------------------------------------------------------
  // Sending end
  // ----------------------------------------------------------------------

  credit_sender u_sender (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_data          (in_data),
    .in_ready         (in_ready),
    .credit_hold      (credit_hold),
    .credit_available (credit_available),
    .ret_valid        (snd_ret_valid),
    .ret_count        (snd_ret_count),
    .fwd_valid        (snd_fwd_valid),
    .fwd_data         (snd_fwd_data)
  );

  // ----------------------------------------------------------------------
  // Link in both directions
  // ----------------------------------------------------------------------

  // Flits toward the receiver
  link_retimer #(
    .Stages (`CL_LINK_STAGES),
    .Width  (`CL_DATA_W)
  ) u_fwd_retimer (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (snd_fwd_valid),
    .in_payload  (snd_fwd_data),
    .out_valid   (rcv_fwd_valid),
    .out_payload (rcv_fwd_data)
  );

  // Credit counts back toward the sender
  link_retimer #(
    .Stages (`CL_LINK_STAGES),
    .Width  (`CL_CHG_W)
  ) u_ret_retimer (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (rcv_ret_valid),
    .in_payload  (rcv_ret_count),
    .out_valid   (snd_ret_valid),
    .out_payload (snd_ret_count)
  );

  // ----------------------------------------------------------------------
  // Receiving end
  // ----------------------------------------------------------------------

  credit_receiver u_receiver (
    .clk       (clk),
    .rst_n     (rst_n),
    .fwd_valid (rcv_fwd_valid),
    .fwd_data  (rcv_fwd_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .ret_valid (rcv_ret_valid),
    .ret_count (rcv_ret_count)
  );

endmodule

/* dv/credit_link_checker.sv */
// Scoreboard and credit checks for the credit link
// Watches the DUT ports only; expected credit_available values arrive from the stim replay
// test_id 0 is the reset phase and 8'hff the final drain
`timescale 1ns/100ps
`include "credit_link_consts.svh"

module credit_link_checker (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         in_valid,
  input  credit_link_pkg::flit_t       in_data,
  input  logic                         in_ready,
  input  logic                         out_valid,
  input  credit_link_pkg::flit_t       out_data,
  input  logic                         out_ready,
  input  credit_link_pkg::credit_cnt_t credit_hold,
  input  credit_link_pkg::credit_cnt_t credit_available,
  input  logic [7:0]                   test_id,
  input  logic                         exp_check,
  input  credit_link_pkg::credit_cnt_t exp_avail,
  output logic                         drained,
  output int                           error_count
);
  import credit_link_pkg::*;

  localparam int Depth = `CL_BUF_DEPTH;

  flit_t      sb_q[$];
  int         reset_edges;
  logic       first_edge;
  logic [7:0] cur_test;
  int         test_errors;
  int         tests_passed;
  int         tests_failed;
  int         size_before;

  initial begin
    drained      = 1'b0;
    error_count  = 0;
    reset_edges  = 0;
    first_edge   = 1'b0;
    cur_test     = 8'h00;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
  end

  // Wrong value seen on a port
  task automatic report_mismatch(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  // Protocol breaks that carry no single wrong value
  task automatic report_failure(input string msg);
    $display("Check failed at %0t ns: %s", $time, msg);
    error_count++;
    test_errors++;
  endtask

  // One result line per finished test
  task automatic close_test(input logic [7:0] id);
    string label;
    if (id == 8'h00) begin
      label = "reset";
    end else if (id == 8'hff) begin
      label = "drain";
    end else begin
      label = $sformatf("test %0d", id);
    end
    if (test_errors == 0) begin
      $display("%s: passed", label);
      tests_passed++;
    end else begin
      $display("%s: FAILED with %0d errors", label, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // ----------------------------------------------------------------------
  // Per-edge checks, sampled before the DUT registers update
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    if (!rst_n) begin
      reset_edges++;
      first_edge = 1'b1;
      // Pool is still unknown at the very first edge
      if (reset_edges > 1 &&
          (in_ready !== 1'b0 || out_valid !== 1'b0 || credit_available !== '0)) begin
        report_mismatch($sformatf("in reset in_ready %0b out_valid %0b credit_available %0d",
                                  in_ready, out_valid, credit_available));
      end
    end else if (!drained) begin
      // Registers still hold reset values here
      if (first_edge && (in_ready !== 1'b0 || out_valid !== 1'b0)) begin
        report_mismatch($sformatf("after reset in_ready %0b out_valid %0b",
                                  in_ready, out_valid));
      end
      first_edge = 1'b0;

      if (test_id != cur_test) begin
        close_test(cur_test);
        cur_test = test_id;
      end

      // Window rule: an accept needs a free slot beyond the withheld credits
      size_before = sb_q.size();
      if (in_valid && in_ready && size_before + 1 > Depth - int'(credit_hold)) begin
        report_failure($sformatf("flit accepted with %0d outstanding and hold %0d",
                                 size_before, credit_hold));
      end

      // Oldest first, pop before push
      if (out_valid && out_ready) begin
        if (sb_q.size() == 0) begin
          report_failure("flit delivered while none was outstanding");
        end else begin
          if (out_data !== sb_q[0]) begin
            report_mismatch($sformatf("out_data %h, expected %h", out_data, sb_q[0]));
          end
          void'(sb_q.pop_front());
        end
      end
      if (in_valid && in_ready) begin
        sb_q.push_back(in_data);
      end

      if (sb_q.size() > Depth) begin
        report_failure($sformatf("%0d flits outstanding, more than the buffer holds",
                                 sb_q.size()));
      end

      if (exp_check && credit_available !== exp_avail) begin
        report_mismatch($sformatf("credit_available %0d, expected %0d",
                                  credit_available, exp_avail));
      end

      // Drain done once all flits are out and every credit is home
      if (test_id == 8'hff && sb_q.size() == 0 &&
          int'(credit_available) == Depth - int'(credit_hold)) begin
        close_test(cur_test);
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        drained <= 1'b1;
      end
    end
  end

endmodule

/* dv/credit_link_tb.sv */
// Testbench for the credit link, replaying dv/credit_link_stim.txt cycle by cycle
// Run from the project root so the stim path resolves
// Inputs change on the falling edge; the checker samples on the rising edge
`timescale 1ns/100ps
`include "credit_link_consts.svh"

module credit_link_tb;
  import credit_link_pkg::*;

  localparam int RecWords   = 8;
  localparam int MaxRecs    = 64;
  localparam int ResetCyc   = 10;
  localparam int LoopCycles = 2 * `CL_LINK_STAGES + 4;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  flit_t       in_data;
  logic        in_ready;
  logic        out_valid;
  flit_t       out_data;
  logic        out_ready;
  credit_cnt_t credit_hold;
  credit_cnt_t credit_available;
  logic [7:0]  test_id;
  logic        exp_check;
  credit_cnt_t exp_avail;
  logic        drained;
  int          error_count;

  // RecWords stim words per record
  logic [31:0] stim_mem [RecWords*MaxRecs];
  int          num_recs;
  int          total_cycles;
  int          cycle_limit;
  int          cycle_count;

  credit_link dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_data          (in_data),
    .in_ready         (in_ready),
    .out_valid        (out_valid),
    .out_data         (out_data),
    .out_ready        (out_ready),
    .credit_hold      (credit_hold),
    .credit_available (credit_available)
  );

  credit_link_checker chk (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_data          (in_data),
    .in_ready         (in_ready),
    .out_valid        (out_valid),
    .out_data         (out_data),
    .out_ready        (out_ready),
    .credit_hold      (credit_hold),
    .credit_available (credit_available),
    .test_id          (test_id),
    .exp_check        (exp_check),
    .exp_avail        (exp_avail),
    .drained          (drained),
    .error_count      (error_count)
  );

  // ----------------------------------------------------------------------
  // Clock and run-length guard
  // ----------------------------------------------------------------------

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: link did not drain");
      $display("Testbench failed");
      $finish;
    end
  end

  // Drive one record for its cycle count, starting on a falling edge
  task automatic replay_record(input int rec);
    int base;
    int count;
    base  = rec * RecWords;
    count = int'(stim_mem[base+1]);
    for (int k = 0; k < count; k++) begin
      test_id     = stim_mem[base][7:0];
      in_valid    = stim_mem[base+2][0];
      out_ready   = stim_mem[base+3][0];
      credit_hold = credit_cnt_t'(stim_mem[base+4]);
      if (stim_mem[base+5][0]) begin
        in_data = $urandom;
      end else begin
        in_data = stim_mem[base+6] + k;
      end
      // Expected value applies to the last cycle of the record
      exp_avail = credit_cnt_t'(stim_mem[base+7]);
      exp_check = (k == count - 1) && (stim_mem[base+7] != 32'hf);
      @(negedge clk);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    out_ready   = 1'b0;
    credit_hold = '0;
    test_id     = 8'h00;
    exp_check   = 1'b0;
    exp_avail   = '0;
    cycle_count = 0;
    cycle_limit = 1000;
    void'($urandom(32'h1d9aa4ba));

    // A zero test field ends the list
    for (int i = 0; i < RecWords * MaxRecs; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("dv/credit_link_stim.txt", stim_mem);
    num_recs     = 0;
    total_cycles = 0;
    while (num_recs < MaxRecs && stim_mem[num_recs*RecWords] != 0) begin
      total_cycles += int'(stim_mem[num_recs*RecWords+1]);
      num_recs++;
    end
    cycle_limit = ResetCyc + total_cycles + 4 * LoopCycles + 50;

    repeat (ResetCyc) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < num_recs; r++) begin
      replay_record(r);
    end

    // Drain with the last withhold left in place
    test_id   = 8'hff;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    exp_check = 1'b0;
    while (!drained) @(posedge clk);

    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* credit_link.f */
+incdir+hdl
hdl/credit_link_pkg.sv
hdl/credit_counter.sv
hdl/link_retimer.sv
hdl/credit_sender.sv
hdl/credit_receiver.sv
hdl/credit_link.sv
dv/credit_link_checker.sv
dv/credit_link_tb.sv

/* Makefile */
# Verilator lint and simulation for the credit link

VERILATOR := verilator
VFLAGS    := --timing
TOP       := credit_link_tb
RTL_TOP   := credit_link
FILELIST  := credit_link.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

# RTL on its own, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run from the project root, then look for the pass line in the log
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/credit_link_stim.txt */
// test count in_valid out_ready credit_hold random data exp_available
// One record per line, held for count cycles; data steps by one each cycle; exp f = no check
// Test 1 initial credits crossing the link after reset
1 1 0 1 0 0 00000000 0
1 3 0 1 0 0 00000000 0
1 1 0 1 0 0 00000000 2
1 1 0 1 0 0 00000000 4
1 1 0 1 0 0 00000000 6
1 5 0 1 0 0 00000000 8
// Test 2 ordered burst with the consumer always ready
2 e 1 1 0 0 a0000000 f
2 10 0 1 0 0 00000000 8
// Test 3 consumer stalled until the sender runs dry, then drained
3 14 1 0 0 1 00000000 0
3 10 0 1 0 0 00000000 8
// Test 4 three credits withheld, then six during traffic
4 10 1 0 3 0 b0000000 0
4 10 0 1 3 0 00000000 5
4 14 1 1 6 1 00000000 f
4 10 0 1 6 0 00000000 2
// Test 5 withhold raised to seven in the middle of a burst
5 6 1 1 0 0 c0000000 f
5 e 1 1 7 0 c1000000 f
5 10 0 1 7 0 00000000 1
// Test 6 long random burst, ending with two credits withheld
6 28 1 1 0 1 00000000 f
6 c 1 1 2 1 00000000 f
// End of list
0 0 0 0 0 0 00000000 0
